// File: alu_pkg.sv
/*
 * Shared constants for the RV32 integer execute stage.
 * Op codes are a plain enumeration from zero and are not RISC-V funct fields,
 * so the decode stage must translate before issue.
 * Only RV32I ALU, branch and jump operations are encoded.
 */
package alu_pkg;

   // data and address width
   localparam int XLEN    = 32;

   // op code width, room for 32 codes
   localparam int OP_W    = 5;

   // shift amount width for XLEN bit operands
   localparam int SHAMT_W = 5;

   // width of the 2-bit branch history counter
   localparam int HIST_W  = 2;

   // link offset for jal/jalr, no compressed pc+2 links
   localparam logic [XLEN-1:0] LINK_STEP = XLEN'(4);

   // arithmetic and logic ops
   localparam logic [OP_W-1:0] OP_ADD  = 5'd0;
   localparam logic [OP_W-1:0] OP_SUB  = 5'd1;
   localparam logic [OP_W-1:0] OP_SLT  = 5'd2;
   localparam logic [OP_W-1:0] OP_SLTU = 5'd3;
   localparam logic [OP_W-1:0] OP_AND  = 5'd4;
   localparam logic [OP_W-1:0] OP_OR   = 5'd5;
   localparam logic [OP_W-1:0] OP_XOR  = 5'd6;

   // shifts, amount taken from b
   localparam logic [OP_W-1:0] OP_SLL  = 5'd7;
   localparam logic [OP_W-1:0] OP_SRL  = 5'd8;
   localparam logic [OP_W-1:0] OP_SRA  = 5'd9;

   // conditional branches, kept contiguous so decode can use a range
   localparam logic [OP_W-1:0] OP_BEQ  = 5'd10;
   localparam logic [OP_W-1:0] OP_BNE  = 5'd11;
   localparam logic [OP_W-1:0] OP_BLT  = 5'd12;
   localparam logic [OP_W-1:0] OP_BGE  = 5'd13;
   localparam logic [OP_W-1:0] OP_BLTU = 5'd14;
   localparam logic [OP_W-1:0] OP_BGEU = 5'd15;

   // unconditional jumps
   // jal expects a = pc and b = offset, jalr expects a = rs1 and b = imm
   localparam logic [OP_W-1:0] OP_JAL  = 5'd16;
   localparam logic [OP_W-1:0] OP_JALR = 5'd17;

endpackage

// File: alu_stage_if.sv
/*
 * Registered operation as seen by the execute logic.
 * valid and fire already include the flush, so a flushed item never fires.
 * clk is carried only for checks in the execute modules.
 */
`timescale 1ns/1ns

interface alu_stage_if (
   input logic clk
);

   logic                         valid;
   logic                         fire;
   logic [alu_pkg::OP_W-1:0]     op;
   logic [alu_pkg::XLEN-1:0]     a;
   logic [alu_pkg::XLEN-1:0]     b;
   logic [alu_pkg::XLEN-1:0]     pc;
   // branch displacement, already sign extended
   logic [alu_pkg::XLEN-1:0]     offset;
   logic                         pred_taken;
   logic [alu_pkg::HIST_W-1:0]   hist;

   // the issue register owns every field
   modport issue (
      output valid,
      output fire,
      output op,
      output a,
      output b,
      output pc,
      output offset,
      output pred_taken,
      output hist
   );

   modport exec (
      input  clk,
      input  valid,
      input  fire,
      input  op,
      input  a,
      input  b,
      input  pc,
      input  offset,
      input  pred_taken,
      input  hist
   );

endinterface

// File: alu_issue_reg.sv
/*
 * One-entry operand register with valid/ready on both sides.
 * A new item can enter on the edge where the held one leaves.
 * flush_i drops the held item and blocks acceptance in the same cycle.
 */
`timescale 1ns/1ns

module alu_issue_reg (
   input  logic                         clk,
   input  logic                         reset_i,
   input  logic                         flush_i,
   input  logic                         in_valid_i,
   output logic                         in_ready_o,
   input  logic [alu_pkg::OP_W-1:0]     op_i,
   input  logic [alu_pkg::XLEN-1:0]     a_i,
   input  logic [alu_pkg::XLEN-1:0]     b_i,
   input  logic [alu_pkg::XLEN-1:0]     pc_i,
   input  logic [alu_pkg::XLEN-1:0]     offset_i,
   input  logic                         pred_taken_i,
   input  logic [alu_pkg::HIST_W-1:0]   hist_i,
   input  logic                         out_ready_i,
   alu_stage_if.issue                   stage
);

   import alu_pkg::*;

   logic                held_q;
   logic                accept;
   logic [OP_W-1:0]     op_q;
   logic [XLEN-1:0]     a_q;
   logic [XLEN-1:0]     b_q;
   logic [XLEN-1:0]     pc_q;
   logic [XLEN-1:0]     offset_q;
   logic                pred_taken_q;
   logic [HIST_W-1:0]   hist_q;

   // a flushed item is hidden at once, it must not reach the output
   assign stage.valid = held_q & ~flush_i;
   assign stage.fire  = stage.valid & out_ready_i;

   // free slot, or the held item leaves on this edge
   assign in_ready_o  = ~flush_i & (~held_q | out_ready_i);
   assign accept      = in_valid_i & in_ready_o;

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         held_q <= 1'b0;
      end
      else if (flush_i)
      begin
         held_q <= 1'b0;
      end
      else if (accept)
      begin
         held_q <= 1'b1;
      end
      else if (stage.fire)
      begin
         held_q <= 1'b0;
      end
   end

   // payload only loads on acceptance
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q         <= op_i;
         a_q          <= a_i;
         b_q          <= b_i;
         pc_q         <= pc_i;
         offset_q     <= offset_i;
         pred_taken_q <= pred_taken_i;
         hist_q       <= hist_i;
      end
   end

   assign stage.op         = op_q;
   assign stage.a          = a_q;
   assign stage.b          = b_q;
   assign stage.pc         = pc_q;
   assign stage.offset     = offset_q;
   assign stage.pred_taken = pred_taken_q;
   assign stage.hist       = hist_q;

   // a stalled item must not change under the consumer
   a_hold_stable : assert property (
      @(posedge clk) disable iff (reset_i)
      (stage.valid && !stage.fire) |=> $stable({op_q, a_q, b_q, pc_q, offset_q})
   );

endmodule

// File: alu_datapath.sv
/*
 * Arithmetic, logic and shift unit of the execute stage.
 * One adder serves add, sub, set-less-than, branch compares and jump targets.
 * Branch ops return zero, jumps return the link address from branch_resolve.
 * Shift amount is b[4:0], upper bits of b are ignored.
 */
`timescale 1ns/1ns

module alu_datapath (
   alu_stage_if.exec                   stage,
   input  logic                        link_sel_i,
   input  logic [alu_pkg::XLEN-1:0]    link_pc_i,
   output logic [alu_pkg::XLEN-1:0]    sum_o,
   output logic                        lt_o,
   output logic                        eq_o,
   output logic [alu_pkg::XLEN-1:0]    result_o
);

   import alu_pkg::*;

   logic                  use_sub;
   logic                  is_unsigned;
   logic                  is_sll;
   logic                  is_sra;
   logic [XLEN-1:0]       b_m;
   logic                  cout;
   logic                  ov;
   logic [XLEN-1:0]       lout;
   logic [SHAMT_W-1:0]    shamt;
   logic [SHAMT_W-1:0]    sh_amt;
   logic [2*XLEN-2:0]     sh_ext;
   logic [2*XLEN-2:0]     sh_long;
   logic [XLEN-1:0]       sh_mask;
   logic [XLEN-1:0]       sh_out;

   // compares go through the subtractor as well
   assign use_sub     = (stage.op inside {OP_SUB, OP_SLT, OP_SLTU}) |
                        (stage.op inside {[OP_BEQ:OP_BGEU]});
   assign is_unsigned = stage.op inside {OP_SLTU, OP_BLTU, OP_BGEU};

   assign b_m = use_sub ? ~stage.b : stage.b;

   assign {cout, sum_o} = {1'b0, stage.a} + {1'b0, b_m} + {{XLEN{1'b0}}, use_sub};

   // signed overflow when both inputs agree in sign and the sum does not
   assign ov = (~stage.a[XLEN-1] & ~b_m[XLEN-1] &  sum_o[XLEN-1]) |
               ( stage.a[XLEN-1] &  b_m[XLEN-1] & ~sum_o[XLEN-1]);

   // unsigned borrow shows as a missing carry
   assign lt_o = is_unsigned ? ~cout : (sum_o[XLEN-1] ^ ov);
   assign eq_o = (stage.a == stage.b);

   always_comb
   begin
      case (stage.op)
         OP_AND:  lout = stage.a & stage.b;
         OP_OR:   lout = stage.a | stage.b;
         OP_XOR:  lout = stage.a ^ stage.b;
         default: lout = '0;
      endcase
   end

   // funnel shifter, everything is a right shift of {upper, a}
   assign is_sll = (stage.op == OP_SLL);
   assign is_sra = (stage.op == OP_SRA);
   assign shamt  = stage.b[SHAMT_W-1:0];

   // left shift by n is a right shift by XLEN-n of a doubled word
   assign sh_amt = is_sll ? (~shamt + 1'b1) : shamt;

   assign sh_ext[XLEN-1:0]      = stage.a;
   assign sh_ext[2*XLEN-2:XLEN] = is_sra ? {(XLEN-1){stage.a[XLEN-1]}} :
                                  is_sll ? stage.a[XLEN-2:0]           :
                                           '0;

   assign sh_long = sh_ext >> sh_amt;

   // clear the bits that wrapped around on a left shift
   assign sh_mask = is_sll ? ({XLEN{1'b1}} << shamt) : {XLEN{1'b1}};
   assign sh_out  = sh_long[XLEN-1:0] & sh_mask;

   always_comb
   begin
      if (link_sel_i)
      begin
         result_o = link_pc_i;
      end
      else
      begin
         case (stage.op)
            OP_ADD, OP_SUB:          result_o = sum_o;
            OP_SLT, OP_SLTU:         result_o = {{(XLEN-1){1'b0}}, lt_o};
            OP_AND, OP_OR, OP_XOR:   result_o = lout;
            OP_SLL, OP_SRL, OP_SRA:  result_o = sh_out;
            // branches write no register
            default:                 result_o = '0;
         endcase
      end
   end

endmodule

// File: branch_resolve.sv
/*
 * Branch and jump resolution for the execute stage.
 * Jumps always flush to the main adder sum with bit 0 cleared.
 * flush_o is only raised during a fire cycle; flush_path_o, pred_correct_o
 * and hist_o mean something only then.
 */
`timescale 1ns/1ns

module branch_resolve (
   alu_stage_if.exec                    stage,
   input  logic [alu_pkg::XLEN-1:0]     sum_i,
   input  logic                         lt_i,
   input  logic                         eq_i,
   output logic                         link_sel_o,
   output logic [alu_pkg::XLEN-1:0]     link_pc_o,
   output logic                         flush_o,
   output logic [alu_pkg::XLEN-1:0]     flush_path_o,
   output logic                         pred_correct_o,
   output logic [alu_pkg::HIST_W-1:0]   hist_o
);

   import alu_pkg::*;

   logic                is_branch;
   logic                is_jump;
   logic                taken;
   logic                mispredict;
   logic [XLEN-1:0]     target;
   logic [XLEN-1:0]     seq_pc;
   logic [HIST_W-1:0]   new_hist;

   assign is_branch = stage.op inside {[OP_BEQ:OP_BGEU]};
   assign is_jump   = stage.op inside {OP_JAL, OP_JALR};

   // lt_i is already signed or unsigned according to the op
   always_comb
   begin
      case (stage.op)
         OP_BEQ:             taken = eq_i;
         OP_BNE:             taken = ~eq_i;
         OP_BLT, OP_BLTU:    taken = lt_i;
         OP_BGE, OP_BGEU:    taken = ~lt_i;
         OP_JAL, OP_JALR:    taken = 1'b1;
         default:            taken = 1'b0;
      endcase
   end

   // taken target and fall-through address
   assign target = stage.pc + stage.offset;
   assign seq_pc = stage.pc + LINK_STEP;

   assign link_sel_o = is_jump;
   assign link_pc_o  = seq_pc;

   // a branch flushes to the path it did not predict
   always_comb
   begin
      if (is_jump)
      begin
         flush_path_o = {sum_i[XLEN-1:1], 1'b0};
      end
      else if (taken)
      begin
         flush_path_o = target;
      end
      else
      begin
         flush_path_o = seq_pc;
      end
   end

   assign mispredict     = is_jump | (is_branch & (taken ^ stage.pred_taken));
   assign flush_o        = stage.fire & mispredict;
   assign pred_correct_o = is_branch & ~(taken ^ stage.pred_taken);

   // 2-bit history, next state from {hist, taken}
   always_comb
   begin
      case ({stage.hist, taken})
         3'b000:  new_hist = 2'b01;
         3'b010:  new_hist = 2'b01;
         3'b100:  new_hist = 2'b00;
         3'b110:  new_hist = 2'b10;
         3'b001:  new_hist = 2'b10;
         3'b011:  new_hist = 2'b00;
         default: new_hist = 2'b11;
      endcase
   end

   // plain ALU ops pass the history through
   assign hist_o = (is_branch | is_jump) ? new_hist : stage.hist;

   // fire comes from the issue register, so a flush must come with a live item
   a_flush_valid : assert property (
      @(posedge stage.clk) flush_o |-> stage.valid
   );

endmodule

// File: alu_top.sv
/*
 * RV32 integer execute stage with a one-entry operand register.
 * Latency is one cycle: the result is combinational from the held operands.
 * flush_i drops the held item and holds in_ready_o low for that cycle.
 */
`timescale 1ns/1ns

module alu_top (
   input  logic                         clk,
   input  logic                         reset_i,
   input  logic                         flush_i,
   input  logic                         in_valid_i,
   output logic                         in_ready_o,
   input  logic [alu_pkg::OP_W-1:0]     op_i,
   input  logic [alu_pkg::XLEN-1:0]     a_i,
   input  logic [alu_pkg::XLEN-1:0]     b_i,
   input  logic [alu_pkg::XLEN-1:0]     pc_i,
   input  logic [alu_pkg::XLEN-1:0]     offset_i,
   input  logic                         pred_taken_i,
   input  logic [alu_pkg::HIST_W-1:0]   hist_i,
   output logic                         out_valid_o,
   input  logic                         out_ready_i,
   output logic [alu_pkg::XLEN-1:0]     result_o,
   output logic                         flush_o,
   output logic [alu_pkg::XLEN-1:0]     flush_path_o,
   output logic                         pred_correct_o,
   output logic [alu_pkg::HIST_W-1:0]   hist_o
);

   import alu_pkg::*;

   logic                link_sel;
   logic [XLEN-1:0]     link_pc;
   logic [XLEN-1:0]     sum;
   logic                lt;
   logic                eq;

   alu_stage_if stage (.clk(clk));

   alu_issue_reg i_issue_reg (
      .clk          (clk),
      .reset_i      (reset_i),
      .flush_i      (flush_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .op_i         (op_i),
      .a_i          (a_i),
      .b_i          (b_i),
      .pc_i         (pc_i),
      .offset_i     (offset_i),
      .pred_taken_i (pred_taken_i),
      .hist_i       (hist_i),
      .out_ready_i  (out_ready_i),
      .stage        (stage.issue)
   );

   alu_datapath i_datapath (
      .stage        (stage.exec),
      .link_sel_i   (link_sel),
      .link_pc_i    (link_pc),
      .sum_o        (sum),
      .lt_o         (lt),
      .eq_o         (eq),
      .result_o     (result_o)
   );

   branch_resolve i_branch_resolve (
      .stage          (stage.exec),
      .sum_i          (sum),
      .lt_i           (lt),
      .eq_i           (eq),
      .link_sel_o     (link_sel),
      .link_pc_o      (link_pc),
      .flush_o        (flush_o),
      .flush_path_o   (flush_path_o),
      .pred_correct_o (pred_correct_o),
      .hist_o         (hist_o)
   );

   assign out_valid_o = stage.valid;

endmodule

// File: tb_alu.sv
/*
 * Random testbench for the RV32 execute stage, seeded, so every run repeats.
 * A queue model follows the accepted items and concurrent assertions compare
 * the outputs against it at every edge.
 */
`timescale 1ns/1ns

module tb_alu;

   import alu_pkg::*;

   localparam int N_CYCLES = 4000;
   localparam int WAIT_MAX = 50;
   localparam int ITEM_W   = OP_W + 4*XLEN + 1 + HIST_W;

   logic                clk = 1'b0;
   logic                reset_i;
   logic                flush_i;
   logic                in_valid_i;
   logic                in_ready_o;
   logic [OP_W-1:0]     op_i;
   logic [XLEN-1:0]     a_i;
   logic [XLEN-1:0]     b_i;
   logic [XLEN-1:0]     pc_i;
   logic [XLEN-1:0]     offset_i;
   logic                pred_taken_i;
   logic [HIST_W-1:0]   hist_i;
   logic                out_valid_o;
   logic                out_ready_i;
   logic [XLEN-1:0]     result_o;
   logic                flush_o;
   logic [XLEN-1:0]     flush_path_o;
   logic                pred_correct_o;
   logic [HIST_W-1:0]   hist_o;

   integer              seed = 11925;
   logic [ITEM_W-1:0]   model_q[$];
   // head of the model and what the DUT must show for it
   logic                exp_valid = 1'b0;
   logic [OP_W-1:0]     h_op;
   logic [XLEN-1:0]     h_a;
   logic [XLEN-1:0]     h_b;
   logic [XLEN-1:0]     h_pc;
   logic [XLEN-1:0]     h_off;
   logic                h_pred;
   logic [HIST_W-1:0]   h_hist;
   logic                h_branch;
   logic                taken;
   logic                exp_ctrl;
   logic [XLEN-1:0]     exp_result;
   logic                exp_flush;
   logic                exp_pred_ok;
   logic [XLEN-1:0]     exp_path;
   logic [HIST_W-1:0]   exp_hist;
   logic [XLEN-1:0]     last_result;
   logic                stall_q = 1'b0;
   int                  fired [0:31];
   int                  flush_drops;
   int                  stalls;
   int                  mispredicts;
   int                  predicts_ok;
   string               gap;

   wire exp_out_valid = exp_valid && !flush_i;
   wire exp_fire      = exp_out_valid && out_ready_i;
   wire exp_ready     = !flush_i && (!exp_valid || out_ready_i);

   alu_top i_dut (.*);

   always #4 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string sig, input logic [XLEN-1:0] exp_v,
                                  input logic [XLEN-1:0] act_v);
      abort_run($sformatf("FAIL %s expected %h actual %h", sig, exp_v, act_v));
   endtask

   function automatic logic [XLEN-1:0] ref_alu(input logic [OP_W-1:0] op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
         OP_SLTU: return (a < b) ? 1 : 0;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLL:  return a << b[4:0];
         OP_SRL:  return a >> b[4:0];
         OP_SRA:  return $signed(a) >>> b[4:0];
         default: return '0;
      endcase
   endfunction

   // jumps count as taken
   function automatic logic ref_taken(input logic [OP_W-1:0] op,
                                      input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
      case (op)
         OP_BEQ:  return a == b;
         OP_BNE:  return a != b;
         OP_BLT:  return $signed(a) < $signed(b);
         OP_BGE:  return $signed(a) >= $signed(b);
         OP_BLTU: return a < b;
         OP_BGEU: return a >= b;
         default: return 1'b1;
      endcase
   endfunction

   function automatic logic [HIST_W-1:0] next_hist(input logic [HIST_W-1:0] h, input logic t);
      if (t)
         return (h == 2'b00) ? 2'b10 : (h == 2'b01) ? 2'b00 : 2'b11;
      else
         return (h == 2'b10) ? 2'b00 : (h == 2'b11) ? 2'b10 : 2'b01;
   endfunction

   // mix of edge values and random words
   function automatic logic [XLEN-1:0] pick_operand();
      case ($unsigned($random(seed)) % 6)
         0:       return '0;
         1:       return '1;
         2:       return {1'b1, {(XLEN-1){1'b0}}};
         3:       return XLEN'($unsigned($random(seed)) % 40);
         default: return XLEN'($random(seed));
      endcase
   endfunction

   task automatic drive_item();
      logic [OP_W-1:0] op;
      logic [XLEN-1:0] pc;
      op = OP_W'($unsigned($random(seed)) % 18);
      pc = pick_operand();
      pc[1:0] = 2'b00;
      op_i         <= op;
      a_i          <= (op == OP_JAL) ? pc : pick_operand();
      b_i          <= pick_operand();
      pc_i         <= pc;
      offset_i     <= pick_operand() & ~XLEN'(1);
      pred_taken_i <= 1'($random(seed));
      hist_i       <= HIST_W'($random(seed));
   endtask

   function automatic string coverage_gap();
      for (int op = 0; op <= OP_JALR; op++)
         if (fired[op] == 0)
            return $sformatf("op %0d never reached the output", op);
      if (flush_drops == 0)
         return "no flush dropped a held item";
      if (stalls == 0 || mispredicts == 0 || predicts_ok == 0)
         return "stalls or branch outcomes were not all exercised";
      return "";
   endfunction

   // reference model, updated on every edge from the values before it
   always @(posedge clk)
   begin
      if (reset_i)
         model_q.delete();
      else if (flush_i)
      begin
         if (exp_valid)
            flush_drops++;
         model_q.delete();
      end
      else
      begin
         if (exp_valid && !out_ready_i)
            stalls++;
         if (exp_valid && out_ready_i)
         begin
            fired[h_op]++;
            if (h_branch && exp_flush)
               mispredicts++;
            else if (h_branch)
               predicts_ok++;
            void'(model_q.pop_front());
         end
         if (in_valid_i && model_q.size() == 0)
            model_q.push_back({op_i, a_i, b_i, pc_i, offset_i, pred_taken_i, hist_i});
      end
      last_result = result_o;
      stall_q     = !reset_i && out_valid_o && !out_ready_i;
      exp_valid   = (model_q.size() != 0);
      if (exp_valid)
      begin
         {h_op, h_a, h_b, h_pc, h_off, h_pred, h_hist} = model_q[0];
         h_branch    = h_op inside {[OP_BEQ:OP_BGEU]};
         exp_ctrl    = h_branch || (h_op inside {OP_JAL, OP_JALR});
         taken       = ref_taken(h_op, h_a, h_b);
         exp_result  = ref_alu(h_op, h_a, h_b);
         exp_flush   = 1'b0;
         exp_pred_ok = 1'b0;
         exp_hist    = h_hist;
         exp_path    = '0;
         if (h_branch)
         begin
            exp_flush   = (taken != h_pred);
            exp_pred_ok = (taken == h_pred);
            exp_path    = taken ? h_pc + h_off : h_pc + XLEN'(4);
            exp_hist    = next_hist(h_hist, taken);
         end
         else if (exp_ctrl)
         begin
            exp_result = h_pc + XLEN'(4);
            exp_flush  = 1'b1;
            exp_path   = (h_a + h_b) & ~XLEN'(1);
            exp_hist   = next_hist(h_hist, 1'b1);
         end
      end
   end

   a_out_valid : assert property (@(posedge clk) disable iff (reset_i)
      out_valid_o == exp_out_valid)
      else report_mismatch("out_valid_o", $sampled(exp_out_valid), $sampled(out_valid_o));
   a_in_ready : assert property (@(posedge clk) disable iff (reset_i)
      in_ready_o == exp_ready)
      else report_mismatch("in_ready_o", $sampled(exp_ready), $sampled(in_ready_o));
   a_result : assert property (@(posedge clk) disable iff (reset_i)
      exp_fire |-> result_o == exp_result)
      else report_mismatch("result_o", $sampled(exp_result), $sampled(result_o));
   a_flush : assert property (@(posedge clk) disable iff (reset_i)
      exp_fire |-> flush_o == exp_flush)
      else report_mismatch("flush_o", $sampled(exp_flush), $sampled(flush_o));
   a_pred_ok : assert property (@(posedge clk) disable iff (reset_i)
      exp_fire |-> pred_correct_o == exp_pred_ok)
      else report_mismatch("pred_correct_o", $sampled(exp_pred_ok), $sampled(pred_correct_o));
   a_path : assert property (@(posedge clk) disable iff (reset_i)
      exp_fire && exp_ctrl |-> flush_path_o == exp_path)
      else report_mismatch("flush_path_o", $sampled(exp_path), $sampled(flush_path_o));
   a_hist : assert property (@(posedge clk) disable iff (reset_i)
      exp_fire |-> hist_o == exp_hist)
      else report_mismatch("hist_o", $sampled(exp_hist), $sampled(hist_o));
   a_flush_fire : assert property (@(posedge clk) disable iff (reset_i)
      !(out_valid_o && out_ready_i) |-> !flush_o)
      else abort_run("flush_o was high outside a fire cycle");
   a_stall_ready : assert property (@(posedge clk) disable iff (reset_i)
      out_valid_o && !out_ready_i |-> !in_ready_o)
      else abort_run("in_ready_o was high while the output was stalled");
   a_stall_result : assert property (@(posedge clk) disable iff (reset_i)
      stall_q |-> result_o == last_result)
      else report_mismatch("result_o", $sampled(last_result), $sampled(result_o));
   a_stall_valid : assert property (@(posedge clk) disable iff (reset_i)
      stall_q |-> out_valid_o || flush_i)
      else abort_run("out_valid_o dropped while the output was stalled");
   a_reset : assert property (@(posedge clk)
      reset_i |=> !out_valid_o && !flush_o)
      else abort_run("out_valid_o or flush_o was high right after reset");
   a_flush_block : assert property (@(posedge clk) disable iff (reset_i)
      flush_i |-> !out_valid_o && !in_ready_o)
      else abort_run("an item was visible or accepted during flush_i");

   initial
   begin
      reset_i      = 1'b1;
      flush_i      = 1'b0;
      in_valid_i   = 1'b0;
      out_ready_i  = 1'b0;
      op_i         = '0;
      a_i          = '0;
      b_i          = '0;
      pc_i         = '0;
      offset_i     = '0;
      pred_taken_i = 1'b0;
      hist_i       = '0;
      repeat (8) @(posedge clk);
      reset_i <= 1'b0;
      for (int i = 0; i < WAIT_MAX && !in_ready_o; i++)
         @(negedge clk);
      if (!in_ready_o)
         abort_run("in_ready_o stayed low after reset");
      for (int cyc = 0; cyc < N_CYCLES; cyc++)
      begin
         @(posedge clk);
         // an offered item stays put until it is taken
         if (!in_valid_i || in_ready_o)
         begin
            in_valid_i <= (($random(seed) & 3) != 0);
            drive_item();
         end
         out_ready_i <= (($random(seed) & 3) != 0);
         flush_i     <= (($random(seed) & 15) == 0);
      end
      @(posedge clk);
      in_valid_i  <= 1'b0;
      out_ready_i <= 1'b1;
      flush_i     <= 1'b0;
      for (int i = 0; i < WAIT_MAX && (exp_valid || out_valid_o); i++)
         @(negedge clk);
      if (exp_valid || out_valid_o)
         abort_run("the output did not drain at the end of the run");
      gap = coverage_gap();
      if (gap == "")
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
      begin
         abort_run(gap);
      end
   end

endmodule

// File: sim.f
alu_pkg.sv
alu_stage_if.sv
alu_issue_reg.sv
alu_datapath.sv
branch_resolve.sv
alu_top.sv
tb_alu.sv

// File: Bender.yml
package:
  name: alu_exec_stage

sources:
  # design, in compile order
  - alu_pkg.sv
  - alu_stage_if.sv
  - alu_issue_reg.sv
  - alu_datapath.sv
  - branch_resolve.sv
  - alu_top.sv
  - target: simulation
    files:
      - tb_alu.sv
